// File: tb.f
+incdir+include
rtl/tmds_code_pkg.sv
rtl/tmds_video_pkg.sv
rtl/tmds_word_aligner.sv
rtl/tmds_sync_recognizer.sv
rtl/tmds_symbol_decoder.sv
rtl/tmds_decoder.sv
test/tb_tmds_decoder.sv

// File: test/tb_tmds_decoder.sv
`include "tmds_cfg.svh"

module tb_tmds_decoder;
	timeunit 1ns;
	timeprecision 100ps;

	import tmds_code_pkg::*;
	import tmds_video_pkg::*;

	// one full sweep of every phase at the search timeout
	localparam int SETTLE = 1 << `TMDS_SEARCH_BITS;
	localparam int SWEEP = `TMDS_PHASES * SETTLE;
	localparam int LOCK_LIMIT = SWEEP + 10;
	localparam int SEARCH_LINES = 15;
	localparam int STEADY_LINES = 20;
	localparam int GAP_LINES = 2;
	localparam int RESUME_LINES = 10;
	localparam int LINES = 2 * SEARCH_LINES + STEADY_LINES + GAP_LINES + RESUME_LINES;
	localparam int CYCLE_LIMIT = SWEEP + LINES * 48 + 200;

	// control codes by {vsync, hsync}
	localparam tmds_word_t CTRL_CODES [4] = '{CTRL_00, CTRL_01, CTRL_10, CTRL_11};

	// expected decoder result for one input word
	typedef struct packed {
		logic data_valid;
		tmds_pixel_t pixel;
		tmds_side_t side;
	} expect_t;

	logic hdmi_clk;
	logic bit_clk;
	tmds_chan_words_t raw_words;
	logic video_valid;
	tmds_pixel_t pixel;
	logic data_valid;
	tmds_side_t side;

	integer seed;
	int slip;
	int cycle;
	int mark;
	// consecutive samples with video_valid high
	int vv_run;
	int errors;
	int checks;
	bit searching;
	bit hold_check;
	bit saw_drop;
	// symbol held until the next one arrives to fill the slipped word
	tmds_word_t pend [3];
	expect_t pend_exp;
	expect_t exp_q [$];

	tmds_decoder #(.invert(3'b010)) u_dut (
		.hdmi_clk(hdmi_clk),
		.bit_clk(bit_clk),
		.raw_words(raw_words),
		.video_valid(video_valid),
		.pixel(pixel),
		.data_valid(data_valid),
		.side(side)
	);

	always #4 hdmi_clk = ~hdmi_clk;

	always @(posedge hdmi_clk)
		cycle <= cycle + 1;

	initial
	begin
		wait (cycle >= CYCLE_LIMIT);
		$display("run did not finish within %0d cycles", CYCLE_LIMIT);
		errors++;
		finish_run();
	end

	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	endtask

	task automatic note_failure(string what);
		errors++;
		$display("error at %0d ns: %s", $time, what);
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("mismatch at %0d ns: %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic check_pixel(string name, tmds_pixel_t exp, tmds_pixel_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("mismatch at %0d ns: %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_side(string name, tmds_side_t exp, tmds_side_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("mismatch at %0d ns: %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	// transition coding then optional inversion with the flags on top
	function automatic tmds_word_t encode_data(logic [7:0] b, logic inv, logic use_xor);
		logic [7:0] q;
		q[0] = b[0];
		for (int i = 1; i < 8; i++)
			q[i] = use_xor ? (q[i-1] ^ b[i]) : ~(q[i-1] ^ b[i]);
		return {inv, use_xor, inv ? ~q : q};
	endfunction

	// control codes win over terc4 and anything else is a data byte
	function automatic expect_t expect_for(tmds_word_t s0, logic [7:0] b0, b1, b2);
		expect_t e;
		e = '0;
		e.pixel = '{blue: b0, green: b1, red: b2};
		for (int k = 0; k < 4; k++)
			if (s0 == CTRL_CODES[k])
			begin
				e.side.sync_valid = 1'b1;
				e.side.sync = tmds_sync_t'(k);
			end
		if (!e.side.sync_valid)
			for (int k = 0; k < 16; k++)
				if (s0 == TERC4_TABLE[k])
				begin
					e.side.ctrl_valid = 1'b1;
					e.side.ctrl = terc4_t'(k);
				end
		e.data_valid = !e.side.sync_valid && !e.side.ctrl_valid;
		return e;
	endfunction

	// one cycle of sampling the outputs and driving the slipped words
	task automatic send_symbols(tmds_word_t n0, n1, n2, expect_t ne);
		tmds_word_t nxt [3];
		logic [19:0] pair;
		expect_t e;
		tmds_side_t act_side;
		nxt = '{n0, n1, n2};
		@(negedge hdmi_clk);
		vv_run = video_valid ? vv_run + 1 : 0;
		if (!video_valid)
			saw_drop = 1'b1;
		if (searching && video_valid)
		begin
			searching = 1'b0;
			if (cycle - mark > LOCK_LIMIT)
				note_failure($sformatf("video_valid rose %0d cycles into the search, limit %0d",
					cycle - mark, LOCK_LIMIT));
		end
		if (hold_check)
			check_flag("video_valid", 1'b1, video_valid);
		// result of the word driven three cycles ago
		if (exp_q.size() == 3)
		begin
			e = exp_q.pop_front();
			// skip a short lock that a timeout could still undo
			if (vv_run > SETTLE)
			begin
				act_side = side;
				if (!e.side.sync_valid)
					act_side.sync = '0;
				if (!e.side.ctrl_valid)
					act_side.ctrl = '0;
				check_flag("data_valid", e.data_valid, data_valid);
				check_side("side", e.side, act_side);
				if (e.data_valid)
					check_pixel("pixel", e.pixel, pixel);
			end
		end
		// window read at the slip gives back the pending symbol
		for (int c = 0; c < 3; c++)
		begin
			pair = {pend[c], nxt[c]};
			if (c == 0)
				raw_words.ch0 = pair[10 - slip +: 10];
			else if (c == 1)
				raw_words.ch1 = ~pair[10 - slip +: 10];
			else
				raw_words.ch2 = pair[10 - slip +: 10];
		end
		exp_q.push_back(pend_exp);
		pend = nxt;
		pend_exp = ne;
	endtask

	// blanking burst then 40 symbols of data, sync or terc4 content
	task automatic send_line(bit with_burst);
		tmds_word_t s [3];
		logic [7:0] b [3];
		logic [31:0] r;
		int kind;
		if (with_burst)
			repeat (8)
				send_symbols(CTRL_11, CTRL_00, CTRL_00, expect_for(CTRL_11, '0, '0, '0));
		repeat (40)
		begin
			kind = with_burst ? $unsigned($random(seed)) % 8 : 7;
			for (int c = 0; c < 3; c++)
			begin
				r = $random(seed);
				b[c] = r[7:0];
				s[c] = encode_data(r[7:0], r[8], r[9]);
			end
			if (kind == 0)
				s[0] = CTRL_CODES[$unsigned($random(seed)) % 4];
			else if (kind == 1)
				s[0] = TERC4_TABLE[$unsigned($random(seed)) % 16];
			send_symbols(s[0], s[1], s[2], expect_for(s[0], b[0], b[1], b[2]));
		end
	endtask

	initial
	begin
		hdmi_clk = 1'b0;
		bit_clk = 1'b1;
		raw_words = '0;
		seed = 32'h3a82_1767;
		errors = 0;
		checks = 0;
		vv_run = 0;
		searching = 1'b0;
		hold_check = 1'b0;
		saw_drop = 1'b0;
		pend = '{CTRL_00, CTRL_00, CTRL_00};
		pend_exp = '0;
		slip = $unsigned($random(seed)) % `TMDS_PHASES;
		$display("bit slip %0d", slip);
		// all strobes idle while reset is held
		repeat (16)
		begin
			@(negedge hdmi_clk);
			check_flag("video_valid", 1'b0, video_valid);
			check_flag("data_valid", 1'b0, data_valid);
			check_flag("sync_valid", 1'b0, side.sync_valid);
			check_flag("ctrl_valid", 1'b0, side.ctrl_valid);
		end
		bit_clk = 1'b0;
		// first search starts at phase 0
		mark = cycle;
		searching = 1'b1;
		for (int i = 0; i < SEARCH_LINES && searching; i++)
			send_line(1'b1);
		if (searching)
			note_failure("video_valid did not rise after reset");
		hold_check = 1'b1;
		repeat (STEADY_LINES)
			send_line(1'b1);
		// data keeps flowing but the bursts stop
		hold_check = 1'b0;
		saw_drop = 1'b0;
		repeat (GAP_LINES)
			send_line(1'b0);
		if (!saw_drop)
			note_failure("video_valid stayed high without blanking bursts");
		mark = cycle;
		searching = 1'b1;
		for (int i = 0; i < SEARCH_LINES && searching; i++)
			send_line(1'b1);
		if (searching)
			note_failure("video_valid did not return after bursts resumed");
		hold_check = 1'b1;
		repeat (RESUME_LINES)
			send_line(1'b1);
		finish_run();
	end

endmodule

// File: rtl/tmds_decoder.sv
module tmds_decoder #(
	parameter bit [2:0] invert = 3'b000
) (
	input logic hdmi_clk,
	input logic bit_clk,
	input tmds_video_pkg::tmds_chan_words_t raw_words,
	output logic video_valid,
	output tmds_video_pkg::tmds_pixel_t pixel,
	output logic data_valid,
	output tmds_video_pkg::tmds_side_t side
);
	import tmds_code_pkg::*;
	import tmds_video_pkg::*;

	// shared slip select from channel 0
	tmds_phase_t phase;
	// only channel 0 window feeds the recognizer
	tmds_word_t [1:0] window0;
	tmds_word_t symbol0;
	tmds_word_t symbol1;
	tmds_word_t symbol2;
	logic [7:0] data0;
	logic [7:0] data1;
	logic [7:0] data2;

	tmds_word_aligner #(.invert(invert[0])) u_align0 (
		.hdmi_clk(hdmi_clk),
		.bit_clk(bit_clk),
		.word(raw_words.ch0),
		.phase(phase),
		.window(window0),
		.symbol(symbol0)
	);

	tmds_word_aligner #(.invert(invert[1])) u_align1 (
		.hdmi_clk(hdmi_clk),
		.bit_clk(bit_clk),
		.word(raw_words.ch1),
		.phase(phase),
		.window(),
		.symbol(symbol1)
	);

	tmds_word_aligner #(.invert(invert[2])) u_align2 (
		.hdmi_clk(hdmi_clk),
		.bit_clk(bit_clk),
		.word(raw_words.ch2),
		.phase(phase),
		.window(),
		.symbol(symbol2)
	);

	// blanking on channel 0 sets the slip for all three channels
	tmds_sync_recognizer u_sync (
		.hdmi_clk(hdmi_clk),
		.bit_clk(bit_clk),
		.window(window0),
		.phase(phase),
		.video_valid(video_valid)
	);

	// channel 0 carries sync and data island codes
	tmds_symbol_decoder u_dec0 (
		.hdmi_clk(hdmi_clk),
		.bit_clk(bit_clk),
		.symbol(symbol0),
		.data(data0),
		.data_valid(data_valid),
		.side(side)
	);

	tmds_symbol_decoder u_dec1 (
		.hdmi_clk(hdmi_clk),
		.bit_clk(bit_clk),
		.symbol(symbol1),
		.data(data1),
		.data_valid(),
		.side()
	);

	tmds_symbol_decoder u_dec2 (
		.hdmi_clk(hdmi_clk),
		.bit_clk(bit_clk),
		.symbol(symbol2),
		.data(data2),
		.data_valid(),
		.side()
	);

	assign pixel = '{blue: data0, green: data1, red: data2};

endmodule

// File: rtl/tmds_symbol_decoder.sv
`include "tmds_cfg.svh"

module tmds_symbol_decoder (
	input logic hdmi_clk,
	input logic bit_clk,
	input tmds_code_pkg::tmds_sym_u symbol,
	output logic [`TMDS_DATA_BITS-1:0] data,
	output logic data_valid,
	output tmds_video_pkg::tmds_side_t side
);
	import tmds_code_pkg::*;

	logic [`TMDS_DATA_BITS-1:0] payload_pol;
	logic [`TMDS_DATA_BITS-1:0] decoded;
	logic is_sync;
	logic is_terc4;
	tmds_sync_t sync_code;
	terc4_t terc4_code;
	logic sync_valid;
	logic ctrl_valid;
	tmds_sync_t sync;
	terc4_t ctrl;

	// undo dc balancing inversion first
	assign payload_pol = symbol.data.invert ? ~symbol.data.payload : symbol.data.payload;

	// then undo the transition coding chain
	// bit 0 is sent as is
	always_comb
	begin
		decoded[0] = payload_pol[0];
		for (int i = 1; i < `TMDS_DATA_BITS; i++)
		begin
			if (symbol.data.use_xor)
				decoded[i] = payload_pol[i] ^ payload_pol[i-1];
			else
				decoded[i] = ~(payload_pol[i] ^ payload_pol[i-1]);
		end
	end

	// whole-word compare against the control codes
	always_comb
	begin
		is_sync = 1'b1;
		sync_code = 2'b00;
		case (symbol.word)
			CTRL_00: sync_code = 2'b00;
			CTRL_01: sync_code = 2'b01;
			CTRL_10: sync_code = 2'b10;
			CTRL_11: sync_code = 2'b11;
			default: is_sync = 1'b0;
		endcase
	end

	// terc4 lookup where the table index is the nibble
	always_comb
	begin
		is_terc4 = 1'b0;
		terc4_code = '0;
		for (int k = 0; k < 16; k++)
		begin
			if (symbol.word == TERC4_TABLE[k])
			begin
				is_terc4 = 1'b1;
				terc4_code = terc4_t'(k);
			end
		end
	end

	// one strobe per cycle once symbols flow
	always_ff @(posedge hdmi_clk or posedge bit_clk)
		if (bit_clk)
		begin
			data_valid <= 1'b0;
			sync_valid <= 1'b0;
			ctrl_valid <= 1'b0;
		end
		else
		begin
			sync_valid <= is_sync;
			ctrl_valid <= is_terc4;
			data_valid <= !is_sync && !is_terc4;
		end

	// byte always follows the input
	// sync and ctrl only move on their own codes
	always_ff @(posedge hdmi_clk)
	begin
		data <= decoded;
		if (is_sync)
			sync <= sync_code;
		if (is_terc4)
			ctrl <= terc4_code;
	end

	assign side = '{sync_valid: sync_valid, sync: sync, ctrl_valid: ctrl_valid, ctrl: ctrl};

	one_strobe: assert property (
		@(posedge hdmi_clk) disable iff (bit_clk)
		$onehot0({data_valid, sync_valid, ctrl_valid})
	) else $error("more than one decoder strobe high");

endmodule

// File: rtl/tmds_sync_recognizer.sv
`include "tmds_cfg.svh"

module tmds_sync_recognizer (
	input logic hdmi_clk,
	input logic bit_clk,
	input tmds_code_pkg::tmds_word_t [1:0] window,
	output tmds_video_pkg::tmds_phase_t phase,
	output logic video_valid
);
	import tmds_code_pkg::*;
	import tmds_video_pkg::*;

	localparam tmds_phase_t LAST_PHASE = tmds_phase_t'(`TMDS_PHASES - 1);

	// older half of the previous window
	// it is the word just before window[1]
	tmds_word_t last_word;
	// three consecutive words so every phase sees 20 full bits
	logic [3*`TMDS_WORD_BITS-1:0] ext_window;
	logic [`TMDS_SEARCH_BITS-1:0] counter;
	logic match;
	logic overflow;

	assign ext_window = {last_word, window};

	// two blanking codes back to back at the current slip
	assign match = (ext_window[phase +: 2*`TMDS_WORD_BITS] == {CTRL_11, CTRL_11});

	// all ones means this is the last cycle of the timeout
	assign overflow = &counter;

	always_ff @(posedge hdmi_clk)
	begin
		last_word <= window[1];
	end

	always_ff @(posedge hdmi_clk or posedge bit_clk)
		if (bit_clk)
		begin
			phase <= '0;
			counter <= '0;
			video_valid <= 1'b0;
		end
		else if (match)
		begin
			// locked, restart the timeout
			video_valid <= 1'b1;
			counter <= '0;
		end
		else if (overflow)
		begin
			// no pair for a full timeout, try the next slip
			phase <= (phase == LAST_PHASE) ? '0 : phase + 1'b1;
			video_valid <= 1'b0;
			counter <= '0;
		end
		else
		begin
			counter <= counter + 1'b1;
		end

	phase_below_limit: assert property (
		@(posedge hdmi_clk) disable iff (bit_clk)
		phase < `TMDS_PHASES
	) else $error("recognizer phase %0d reached limit", phase);

	// a phase step needs a full timeout with no pair in between
	phase_step_on_timeout: assert property (
		@(posedge hdmi_clk) disable iff (bit_clk)
		(phase != $past(phase)) |-> $past(overflow && !match)
	) else $error("phase changed without search timeout");

endmodule

// File: rtl/tmds_word_aligner.sv
`include "tmds_cfg.svh"

module tmds_word_aligner #(
	parameter bit invert = 1'b0
) (
	input logic hdmi_clk,
	input logic bit_clk,
	input tmds_code_pkg::tmds_word_t word,
	input tmds_video_pkg::tmds_phase_t phase,
	output tmds_code_pkg::tmds_word_t [1:0] window,
	output tmds_code_pkg::tmds_word_t symbol
);
	import tmds_code_pkg::*;

	// board may swap the pair polarity
	tmds_word_t word_pol;
	logic [2*`TMDS_WORD_BITS-1:0] window_bits;

	assign word_pol = invert ? ~word : word;
	assign window_bits = window;

	// older word moves up, newest word lands in the low half
	always_ff @(posedge hdmi_clk)
	begin
		window <= {window[0], word_pol};
	end

	// take ten bits starting at the slip
	// phase 0 is the newest word as received
	always_ff @(posedge hdmi_clk)
	begin
		symbol <= window_bits[phase +: `TMDS_WORD_BITS];
	end

	// phase comes from the recognizer and must stay inside the window
	phase_in_range: assert property (
		@(posedge hdmi_clk) disable iff (bit_clk)
		phase < `TMDS_PHASES
	) else $error("aligner phase %0d out of range", phase);

endmodule

// File: rtl/tmds_video_pkg.sv
`include "tmds_cfg.svh"

package tmds_video_pkg;

	// one word per channel, channel 0 in the low bits
	typedef struct packed {
		tmds_code_pkg::tmds_word_t ch2;
		tmds_code_pkg::tmds_word_t ch1;
		tmds_code_pkg::tmds_word_t ch0;
	} tmds_chan_words_t;

	// decoded pixel, blue on channel 0
	typedef struct packed {
		logic [`TMDS_DATA_BITS-1:0] blue;
		logic [`TMDS_DATA_BITS-1:0] green;
		logic [`TMDS_DATA_BITS-1:0] red;
	} tmds_pixel_t;

	// channel 0 control and data island results
	// sync and ctrl hold their last decoded value
	typedef struct packed {
		logic sync_valid;
		tmds_code_pkg::tmds_sync_t sync;
		logic ctrl_valid;
		tmds_code_pkg::terc4_t ctrl;
	} tmds_side_t;

	// bit slip select, 0 to phases-1
	typedef logic [$clog2(`TMDS_PHASES)-1:0] tmds_phase_t;

endpackage

// File: rtl/tmds_code_pkg.sv
`include "tmds_cfg.svh"

package tmds_code_pkg;

	// one raw tmds symbol
	typedef logic [`TMDS_WORD_BITS-1:0] tmds_word_t;

	// data period symbol, msb first
	// invert flag, then xor/xnor select, then transition-coded payload
	typedef struct packed {
		logic invert;
		logic use_xor;
		logic [`TMDS_DATA_BITS-1:0] payload;
	} tmds_data_sym_t;

	// same ten bits seen either as a whole code or as data fields
	typedef union packed {
		tmds_word_t word;
		tmds_data_sym_t data;
	} tmds_sym_u;

	// hsync in bit 0, vsync in bit 1
	typedef logic [1:0] tmds_sync_t;

	// data island nibble
	typedef logic [3:0] terc4_t;

	// control period codes, index is {vsync, hsync}
	localparam tmds_word_t CTRL_00 = 10'b1101010100;
	localparam tmds_word_t CTRL_01 = 10'b0010101011;
	localparam tmds_word_t CTRL_10 = 10'b0101010100;
	// blanking code, also used by the aligner as the lock pattern
	localparam tmds_word_t CTRL_11 = 10'b1010101011;

	// terc4 codes, entry k carries nibble k
	localparam tmds_word_t TERC4_TABLE [16] = '{
		10'b1010011100,
		10'b1001100011,
		10'b1011100100,
		10'b1011100010,
		10'b0101110001,
		10'b0100011110,
		10'b0110001110,
		10'b0100111100,
		10'b1011001100,
		10'b0100111001,
		10'b0110011100,
		10'b1011000110,
		10'b1010001110,
		10'b1001110001,
		10'b0101100011,
		10'b1011000011
	};

endpackage

// File: include/tmds_cfg.svh
`ifndef TMDS_CFG_SVH
`define TMDS_CFG_SVH

// width of one tmds symbol on the wire
`define TMDS_WORD_BITS 10

// width of a decoded data byte
`define TMDS_DATA_BITS 8

// number of bit slips the aligner can select
// one per bit of the symbol
`define TMDS_PHASES 10

// search timeout counter width
// phase steps after 2**bits cycles without a control pair
`define TMDS_SEARCH_BITS 6

`endif
